// ==== testbench/wb_test_input.txt ====
# op master addr data sel expected rsp; op W write, R read, rsp A ack or E err
# P pair read: first-finisher, m0 addr, m0 expected, m1 addr, m1 expected, A
W 0 0010000 12345678 f 00000000 A
R 0 0010000 00000000 0 12345678 A
W 1 0018003 cafef00d f 00000000 A
R 0 0018003 00000000 0 cafef00d A
R 1 0010000 00000000 0 12345678 A
W 1 001000f a5a5a5a5 f 00000000 A
R 1 001000f 00000000 0 a5a5a5a5 A
W 0 0010000 aabbccdd 1 00000000 A
R 0 0010000 00000000 0 123456dd A
W 1 0010000 11223344 6 00000000 A
R 1 0010000 00000000 0 122233dd A
W 0 0018003 00ff00ff 8 00000000 A
R 0 0018003 00000000 0 00fef00d A
W 0 0010005 deadbeef 0 00000000 A
R 0 0010005 00000000 0 00000000 A
R 0 8000123 00000000 0 fffffedc A
R 1 fabcdef 00000000 0 f8543210 A
W 0 8000010 11111111 f 00000000 A
R 0 0000010 00000000 0 00000000 E
W 1 001c000 ffffffff f 00000000 E
W 0 0018008 ffffffff f 00000000 E
R 0 0018008 00000000 0 00000000 E
R 1 0018000 00000000 0 00000000 A
W 0 0030001 ffffffff f 00000000 E
R 1 0010001 00000000 0 00000000 A
P 0 0010000 122233dd 0018003 00fef00d A
P 0 001000f a5a5a5a5 0010000 122233dd A
R 0 0018003 00000000 0 00fef00d A
P 1 0010000 122233dd 001000f a5a5a5a5 A
P 1 0018003 00fef00d 0010000 122233dd A

// ==== filelist.f ====
+incdir+verilog
verilog/wb_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_reg_slave.sv
verilog/wb_intercon.sv
verilog/turf_wb_top.sv
testbench/tb_turf_wb.sv

// ==== Makefile ====
TOP := tb_turf_wb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall --top-module turf_wb_top -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_turf_wb.sv ====
`timescale 1ns/100ps
`include "wb_settings.svh"

module tb_turf_wb
    import wb_pkg::*;
();

    logic          clk_i = 1'b0;
    logic          arst_n_i;
    wb_req_t [1:0] m_req;
    wb_rsp_t [1:0] m_rsp;
    wb_req_t       crate_req;
    wb_rsp_t       crate_rsp = '0;
    int            err_count = 0;
    int            pass_count = 0;
    int            fail_count = 0;
    int            cycle_count = 0;
    int            cycle_limit = 0;

    turf_wb_top dut_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ps_req_i    (m_req[0]),
        .ps_rsp_o    (m_rsp[0]),
        .eth_req_i   (m_req[1]),
        .eth_rsp_o   (m_rsp[1]),
        .crate_req_o (crate_req),
        .crate_rsp_i (crate_rsp)
    );

    always #2 clk_i = ~clk_i;

    // Crate slave acks one cycle after the strobe, data is the inverted offset
    always @(negedge clk_i) begin
        crate_rsp.ack <= crate_req.cyc && crate_req.stb && !crate_rsp.ack;
        crate_rsp.dat <= ~wb_data_t'(crate_req.adr);
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic single_access(input string name, input int m, input logic we,
                                 input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel,
                                 input wb_data_t exp, input logic [7:0] rc);
        int         lat;
        wb_req_t    crate_seen;
        wb_rsp_t    rsp;
        logic [7:0] got;
        lat        = 0;
        crate_seen = '0;
        @(negedge clk_i);
        m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
        do begin
            @(negedge clk_i);
            lat++;
            if (crate_req.cyc) begin
                crate_seen = crate_req;
            end
            assert (m_rsp[1-m] == '0) else begin
                $display("%s: response reached master %0d, which made no request", name, 1 - m);
                err_count++;
            end
            rsp = m_rsp[m];
        end while (!rsp.ack && !rsp.err);
        m_req[m] = '0;
        got = rsp.ack ? "A" : "E";
        assert (got == rc) else begin
            $display("Fail %s response: expected %s, actual %s", name, rc, got);
            err_count++;
        end
        check_word(name, "retry", 32'd0, 32'(rsp.rty));
        if (rc == "A" && !we) begin
            check_word(name, "read data", exp, rsp.dat);
        end
        if ((adr & ~`CRATE_MASK) == `CRATE_BASE) begin
            // Crate port sees the offset and the master's own write fields
            check_word(name, "crate cyc and stb", 32'd3,
                       32'({crate_seen.cyc, crate_seen.stb}));
            check_word(name, "crate address", 32'(adr & `CRATE_MASK), 32'(crate_seen.adr));
            check_word(name, "crate write enable", 32'(we), 32'(crate_seen.we));
            check_word(name, "crate write data", dat, crate_seen.dat);
            check_word(name, "crate select", 32'(sel), 32'(crate_seen.sel));
        end else begin
            check_word(name, "latency", 32'd2, 32'(lat));
        end
    endtask

    // Both masters read at once, the winner follows the round-robin order
    task automatic pair_access(input string name, input int first,
                               input wb_addr_t adr0, input wb_data_t exp0,
                               input wb_addr_t adr1, input wb_data_t exp1);
        logic [1:0] done;
        int         first_done;
        wb_rsp_t    rsp;
        done       = '0;
        first_done = -1;
        @(negedge clk_i);
        m_req[0] = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr0, dat: '0, sel: '1};
        m_req[1] = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr1, dat: '0, sel: '1};
        while (done != 2'b11) begin
            @(negedge clk_i);
            for (int m = 0; m < 2; m++) begin
                rsp = m_rsp[m];
                if (!done[m] && (rsp.ack || rsp.err)) begin
                    check_word(name, "ack", 32'd1, 32'(rsp.ack));
                    check_word(name, $sformatf("master %0d data", m), m ? exp1 : exp0, rsp.dat);
                    if (first_done < 0) begin
                        first_done = m;
                    end
                    done[m]  = 1'b1;
                    m_req[m] = '0;
                end else if (done[m] || (m != first && !done[first])) begin
                    // Finished master and the waiting loser hold no grant
                    assert (rsp == '0) else begin
                        $display("%s: master %0d got a response without holding the bus",
                                 name, m);
                        err_count++;
                    end
                end
            end
        end
        check_word(name, "first master", 32'(first), 32'(first_done));
    endtask

    initial begin
        string       lines [$];
        int          line_no [$];
        string       line;
        string       name;
        int          fd;
        int          n;
        int          prev_err;
        logic [7:0]  op;
        logic [7:0]  rc;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        m_req    = '0;
        arst_n_i = 1'b0;
        fd = $fopen("testbench/wb_test_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/wb_test_input.txt");
            err_count++;
        end else begin
            n = 0;
            while ($fgets(line, fd) > 0) begin
                n++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                    line_no.push_back(n);
                end
            end
            $fclose(fd);
        end
        cycle_limit = lines.size() * 20;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        foreach (lines[i]) begin
            name     = $sformatf("line %0d", line_no[i]);
            prev_err = err_count;
            n = $sscanf(lines[i], "%s %h %h %h %h %h %s", op, f1, f2, f3, f4, f5, rc);
            if (n != 7) begin
                $display("%s: stimulus line could not be parsed", name);
                err_count++;
            end else if (op == "P") begin
                pair_access(name, int'(f1), wb_addr_t'(f2), f3, wb_addr_t'(f4), f5);
            end else begin
                single_access(name, int'(f1), op == "W", wb_addr_t'(f2), f3,
                              wb_sel_t'(f4), f5, rc);
            end
            if (err_count == prev_err) begin
                pass_count++;
                $display("%s passed", name);
            end else begin
                fail_count++;
                $display("%s failed", name);
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/turf_wb_top.sv ====
`timescale 1ns/100ps
`include "wb_settings.svh"

module turf_wb_top
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    // Local processor port
    input  wb_req_t ps_req_i,
    output wb_rsp_t ps_rsp_o,
    // Ethernet bridge port
    input  wb_req_t eth_req_i,
    output wb_rsp_t eth_rsp_o,
    // External crate bridge
    output wb_req_t crate_req_o,
    input  wb_rsp_t crate_rsp_i
);

    wb_req_t [`WB_NUM_MASTERS-1:0] m_req;
    wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp;
    wb_req_t                       ctl_req;
    wb_rsp_t                       ctl_rsp;
    wb_req_t                       evctl_req;
    wb_rsp_t                       evctl_rsp;

    // Master 0 is the processor
    assign m_req[0]  = ps_req_i;
    assign m_req[1]  = eth_req_i;
    assign ps_rsp_o  = m_rsp[0];
    assign eth_rsp_o = m_rsp[1];

    wb_intercon u_intercon (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .m_req_i     (m_req),
        .m_rsp_o     (m_rsp),
        .ctl_req_o   (ctl_req),
        .ctl_rsp_i   (ctl_rsp),
        .evctl_req_o (evctl_req),
        .evctl_rsp_i (evctl_rsp),
        .crate_req_o (crate_req_o),
        .crate_rsp_i (crate_rsp_i)
    );

    wb_reg_slave #(
        .NUM_WORDS (16)
    ) u_ctl (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (ctl_req),
        .rsp_o    (ctl_rsp)
    );

    wb_reg_slave #(
        .NUM_WORDS (8)
    ) u_evctl (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (evctl_req),
        .rsp_o    (evctl_rsp)
    );

endmodule

// ==== verilog/wb_intercon.sv ====
`timescale 1ns/100ps
`include "wb_settings.svh"

module wb_intercon
    import wb_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    // Masters
    input  wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
    output wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_o,
    // Control space
    output wb_req_t                       ctl_req_o,
    input  wb_rsp_t                       ctl_rsp_i,
    // Event-control space
    output wb_req_t                       evctl_req_o,
    input  wb_rsp_t                       evctl_rsp_i,
    // Crate bridge
    output wb_req_t                       crate_req_o,
    input  wb_rsp_t                       crate_rsp_i
);

    wb_mst_t cyc_vec;
    wb_mst_t gnt;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    logic    ctl_hit;
    logic    evctl_hit;
    logic    crate_hit;
    logic    any_hit;
    logic    def_err_q;

    function automatic logic addr_hit(
        input wb_addr_t adr,
        input wb_addr_t base,
        input wb_addr_t mask
    );
        return (adr & ~mask) == base;
    endfunction

    // Strobes only reach the decoded slave, which sees its own offset
    function automatic wb_req_t slave_req(
        input wb_req_t  req,
        input logic     hit,
        input wb_addr_t mask
    );
        wb_req_t r;
        r     = req;
        r.cyc = req.cyc && hit;
        r.stb = req.stb && hit;
        r.adr = req.adr & mask;
        return r;
    endfunction

    always_comb begin
        for (int m = 0; m < `WB_NUM_MASTERS; m++) begin
            cyc_vec[m] = m_req_i[m].cyc;
        end
    end

    wb_arbiter u_arbiter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (cyc_vec),
        .gnt_o    (gnt)
    );

    // Grant is one-hot, so at most one request gets through
    always_comb begin
        bus_req = '0;
        for (int m = 0; m < `WB_NUM_MASTERS; m++) begin
            if (gnt[m]) begin
                bus_req = m_req_i[m];
            end
        end
    end

    // Address decode
    assign ctl_hit   = addr_hit(bus_req.adr, `CTL_BASE, `CTL_MASK);
    assign evctl_hit = addr_hit(bus_req.adr, `EVCTL_BASE, `EVCTL_MASK);
    assign crate_hit = addr_hit(bus_req.adr, `CRATE_BASE, `CRATE_MASK);
    assign any_hit   = ctl_hit || evctl_hit || crate_hit;

    assign ctl_req_o   = slave_req(bus_req, ctl_hit, `CTL_MASK);
    assign evctl_req_o = slave_req(bus_req, evctl_hit, `EVCTL_MASK);
    assign crate_req_o = slave_req(bus_req, crate_hit, `CRATE_MASK);

    // Default responder for holes in the map
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            def_err_q <= 1'b0;
        end else begin
            def_err_q <= bus_req.cyc && bus_req.stb && !any_hit && !def_err_q;
        end
    end

    always_comb begin
        bus_rsp = '0;
        if (crate_hit) begin
            bus_rsp = crate_rsp_i;
        end else if (ctl_hit) begin
            bus_rsp = ctl_rsp_i;
        end else if (evctl_hit) begin
            bus_rsp = evctl_rsp_i;
        end else begin
            bus_rsp.err = def_err_q;
        end
    end

    // Non-granted masters see an idle response
    always_comb begin
        for (int m = 0; m < `WB_NUM_MASTERS; m++) begin
            m_rsp_o[m] = gnt[m] ? bus_rsp : '0;
        end
    end

endmodule

// ==== verilog/wb_reg_slave.sv ====
`timescale 1ns/100ps
`include "wb_settings.svh"

module wb_reg_slave
    import wb_pkg::*;
#(
    parameter int NUM_WORDS = `WB_REG_WORDS
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    localparam int IDX_W     = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam int NUM_BYTES = $bits(wb_sel_t);

    wb_data_t         mem [NUM_WORDS];
    wb_data_t         rd_q;
    logic             ack_q;
    logic             err_q;
    logic             access;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // New access only when no response is pending
    assign access   = req_i.cyc && req_i.stb && !ack_q && !err_q;
    assign in_range = req_i.adr < wb_addr_t'(NUM_WORDS);
    assign idx      = req_i.adr[IDX_W-1:0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            for (int w = 0; w < NUM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else begin
            ack_q <= access && in_range;
            err_q <= access && !in_range;
            if (access && in_range && req_i.we) begin
                // Byte lanes
                for (int b = 0; b < NUM_BYTES; b++) begin
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read word lands together with the ack
    always_ff @(posedge clk_i) begin
        if (access && in_range && !req_i.we) begin
            rd_q <= mem[idx];
        end
    end

    assign rsp_o = '{ack: ack_q, err: err_q, rty: 1'b0, dat: rd_q};

endmodule

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/100ps
`include "wb_settings.svh"

module wb_arbiter
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  wb_mst_t req_i,
    output wb_mst_t gnt_o
);

    localparam int NUM_M = `WB_NUM_MASTERS;
    localparam int IDX_W = (NUM_M > 1) ? $clog2(NUM_M) : 1;

    wb_mst_t          gnt_q;
    wb_mst_t          gnt_d;
    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] last_d;

    always_comb begin
        int   idx;
        logic found;
        gnt_d  = gnt_q;
        last_d = last_q;
        found  = 1'b0;
        idx    = 0;
        if (gnt_q == '0) begin
            // Search starts just after the last winner
            for (int i = 1; i <= NUM_M; i++) begin
                idx = (int'(last_q) + i) % NUM_M;
                if (!found && req_i[idx]) begin
                    found      = 1'b1;
                    gnt_d[idx] = 1'b1;
                    last_d     = idx[IDX_W-1:0];
                end
            end
        end else if ((req_i & gnt_q) == '0) begin
            // Owner has ended its cycle
            gnt_d = '0;
        end
    end

    // Last winner starts at the top so master 0 goes first
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gnt_q  <= '0;
            last_q <= IDX_W'(NUM_M - 1);
        end else begin
            gnt_q  <= gnt_d;
            last_q <= last_d;
        end
    end

    assign gnt_o = gnt_q;

endmodule

// ==== verilog/wb_pkg.sv ====
`include "wb_settings.svh"

package wb_pkg;

    // Word address as seen on the shared bus
    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

    typedef logic [`WB_DATA_W-1:0] wb_data_t;

    // One select bit per byte lane
    typedef logic [`WB_SEL_W-1:0] wb_sel_t;

    // One bit per bus master
    typedef logic [`WB_NUM_MASTERS-1:0] wb_mst_t;

    // Master toward slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
    } wb_req_t;

    // Slave back toward master
    typedef struct packed {
        logic     ack;
        logic     err;
        logic     rty;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

// ==== verilog/wb_settings.svh ====
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Bus widths
`define WB_ADDR_W 28
`define WB_DATA_W 32
`define WB_SEL_W (`WB_DATA_W / 8)

// Processor port and Ethernet bridge port
`define WB_NUM_MASTERS 2

// Default register bank depth in words
`define WB_REG_WORDS 16

// A space hits when the address with its mask bits cleared equals the base
`define CTL_BASE   28'h0010000
`define CTL_MASK   28'h7FE7FFF
`define EVCTL_BASE 28'h0018000
`define EVCTL_MASK 28'h7FE3FFF

// Crate bridge owns the whole upper half
`define CRATE_BASE 28'h8000000
`define CRATE_MASK 28'h7FFFFFF

`endif
